// ==== memory_controller.f ====
+incdir+include
hdl/mc_pkg.sv
hdl/mc_request_fifo.sv
hdl/mc_timing_regs.sv
hdl/mc_cmd_sequencer.sv
hdl/memory_controller.sv
sim/tb_clock.sv
sim/dram_model.sv
sim/memory_controller_tb.sv

// ==== Makefile ====
TOP = memory_controller_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f memory_controller.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== sim/memory_controller_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mc_params.svh"

module memory_controller_tb;
	import mc_pkg::*;

	localparam int NBANK  = 1 << `MC_BANK_W;
	localparam int N_SEQ  = 64;
	localparam int N_RAND = 100;
	localparam int N_PROG = 8;
	localparam int N_MIX  = 50;
	localparam int N_BP   = 12;
	localparam int N_REQ  = 2 * (N_SEQ + N_RAND + N_PROG + N_BP) + N_MIX;
	// worst case per request uses trp 6 and trcd 30
	localparam int BASE   = N_REQ * (6 + 30 + `MC_TRFC_RST + 8);
	localparam int LIMIT  = BASE + BASE / 40 * (NBANK + 6 + `MC_TRFC_RST + 8) + 100;

	logic                  clk, arst_n;
	logic                  in_valid, in_request_type;
	logic [`MC_ADDR_W-1:0] in_request_address;
	logic [`MC_DATA_W-1:0] in_request_data;
	logic                  out_busy, write_done, read_done;
	logic [`MC_DATA_W-1:0] data_out;
	logic                  cfg_we;
	logic [1:0]            cfg_addr;
	logic [15:0]           cfg_wdata;
	mc_cmd_t               dram_cmd;
	logic [`MC_DATA_W-1:0] dram_wdata, dram_rdata;
	int                    violations;

	int cyc = 0;
	int errors, wr_accepted, rd_accepted, wdone_cnt, rdone_cnt;
	int act_cnt, pre_cnt, ref_cnt, last_pre, last_ref, bank;
	int cur_trcd, cur_trp, cur_trfc;
	int act_cyc [NBANK];
	int pre_cyc [NBANK];
	logic [31:0]           rng;
	logic                  busy_check, busy_seen;
	logic                  rd_issued; // RD went out in the previous cycle
	logic [`MC_DATA_W-1:0] rd_exp;
	logic [`MC_DATA_W-1:0] sb [logic [`MC_ADDR_W-1:0]]; // scoreboard
	logic [`MC_DATA_W-1:0] exp_rd [$];                  // reads in request order
	logic [`MC_ADDR_W-1:0] addr_q [$];

	tb_clock i_tb_clock (.clk(clk));

	dram_model i_dram_model (
		.clk        (clk),
		.arst_n     (arst_n),
		.dram_cmd   (dram_cmd),
		.dram_wdata (dram_wdata),
		.dram_rdata (dram_rdata),
		.violations (violations)
	);

	memory_controller i_memory_controller (
		.clk                (clk),
		.arst_n             (arst_n),
		.in_valid           (in_valid),
		.in_request_type    (in_request_type),
		.in_request_address (in_request_address),
		.in_request_data    (in_request_data),
		.out_busy           (out_busy),
		.write_done         (write_done),
		.read_done          (read_done),
		.data_out           (data_out),
		.cfg_we             (cfg_we),
		.cfg_addr           (cfg_addr),
		.cfg_wdata          (cfg_wdata),
		.dram_cmd           (dram_cmd),
		.dram_wdata         (dram_wdata),
		.dram_rdata         (dram_rdata)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	// cycle limit
	always @(posedge clk) begin
		cyc++;
		if (cyc > LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// command monitor and read checker, sampled mid-cycle
	always @(negedge clk) begin
		if (arst_n) begin
			if (write_done !== (dram_cmd.op == WR))
				report_error($sformatf("write_done %0b with op %0d", write_done, dram_cmd.op));
			if (read_done !== rd_issued)
				report_error($sformatf("read_done %0b, RD in previous cycle %0b",
					read_done, rd_issued));
			rd_issued = (dram_cmd.op == RD);
			if (write_done)
				wdone_cnt++;
			if (read_done) begin
				rdone_cnt++;
				if (exp_rd.size() == 0) begin
					report_error("read_done with no read outstanding");
				end else begin
					rd_exp = exp_rd.pop_front();
					if (data_out !== rd_exp)
						report_error($sformatf("read data %h, expected %h", data_out, rd_exp));
				end
			end
			if (dram_cmd.op != NOP && cyc - last_ref < cur_trfc)
				report_error($sformatf("op %0d only %0d cycles after REF",
					dram_cmd.op, cyc - last_ref));
			case (dram_cmd.op)
				ACT: begin
					bank = dram_cmd.payload.act.bank;
					if (cyc - pre_cyc[bank] < cur_trp)
						report_error($sformatf("ACT bank %0d %0d cycles after PRE",
							bank, cyc - pre_cyc[bank]));
					act_cyc[bank] = cyc;
					act_cnt++;
				end
				RD, WR: begin
					bank = dram_cmd.payload.col.bank;
					if (cyc - act_cyc[bank] < cur_trcd)
						report_error($sformatf("access bank %0d %0d cycles after ACT",
							bank, cyc - act_cyc[bank]));
				end
				PRE: begin
					pre_cyc[dram_cmd.payload.act.bank] = cyc;
					last_pre = cyc;
					pre_cnt++;
				end
				REF: begin
					if (cyc - last_pre < cur_trp)
						report_error($sformatf("REF %0d cycles after PRE", cyc - last_pre));
					last_ref = cyc;
					ref_cnt++;
				end
				default: ;
			endcase
		end
	end

	// presents one request and holds it until the controller takes it
	task automatic send_req(input logic is_write, input logic [`MC_ADDR_W-1:0] addr,
			input logic [`MC_DATA_W-1:0] data);
		logic taken;
		taken              = 1'b0;
		in_valid           = 1'b1;
		in_request_type    = is_write;
		in_request_address = addr;
		in_request_data    = data;
		while (!taken) begin
			@(negedge clk);
			taken = !out_busy;
			if (out_busy)
				busy_seen = 1'b1;
			@(posedge clk);
			#1;
			if (taken && is_write) begin
				sb[addr] = data;
				wr_accepted++;
			end else if (taken) begin
				exp_rd.push_back(sb[addr]);
				rd_accepted++;
			end
			// only writes in flight here, so queue depth is accepted minus done
			if (busy_check && (out_busy != (wr_accepted - wdone_cnt >= `MC_FIFO_DEPTH)))
				report_error($sformatf("out_busy %0b with %0d writes queued",
					out_busy, wr_accepted - wdone_cnt));
		end
		in_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (wdone_cnt < wr_accepted || rdone_cnt < rd_accepted)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#1;
		if (wdone_cnt != wr_accepted)
			report_error($sformatf("%0d write_done for %0d writes", wdone_cnt, wr_accepted));
		if (rdone_cnt != rd_accepted || exp_rd.size() != 0)
			report_error($sformatf("%0d read_done for %0d reads", rdone_cnt, rd_accepted));
	endtask

	task automatic write_cfg(input logic [1:0] a, input logic [15:0] v);
		cfg_we    = 1'b1;
		cfg_addr  = a;
		cfg_wdata = v;
		@(posedge clk);
		#1;
		cfg_we = 1'b0;
		case (a)
			2'd0:    cur_trcd = v;
			2'd1:    cur_trp  = v;
			2'd3:    cur_trfc = v;
			default: ;
		endcase
	endtask

	task automatic check_idle_outputs(input string when);
		if (out_busy || write_done || read_done)
			report_error($sformatf("status outputs high %s", when));
		if (dram_cmd.op != NOP)
			report_error($sformatf("dram_cmd not NOP %s", when));
	endtask

	task automatic check_reset_state();
		repeat (8) begin
			@(negedge clk);
			check_idle_outputs("during reset");
		end
		@(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		@(negedge clk);
		check_idle_outputs("after reset");
		@(posedge clk);
		#1;
	endtask

	task automatic write_read_sequential();
		int w0;
		w0 = wdone_cnt;
		for (int i = 0; i < N_SEQ; i++)
			send_req(1'b1, `MC_ADDR_W'(i), `MC_DATA_W'(i)); // data equals address
		for (int i = 0; i < N_SEQ; i++)
			send_req(1'b0, `MC_ADDR_W'(i), '0);
		wait_idle();
		if (wdone_cnt - w0 != N_SEQ)
			report_error($sformatf("%0d write_done pulses for %0d writes", wdone_cnt - w0, N_SEQ));
	endtask

	task automatic random_row_misses();
		int a0;
		a0 = act_cnt;
		addr_q.delete();
		for (int i = 0; i < N_RAND; i++) begin
			addr_q.push_back(`MC_ADDR_W'(next_rand()));
			send_req(1'b1, addr_q[i], `MC_DATA_W'(next_rand()));
		end
		for (int i = 0; i < N_RAND; i++)
			send_req(1'b0, addr_q[i], '0);
		wait_idle();
		if (act_cnt - a0 < N_RAND)
			report_error($sformatf("only %0d ACT for %0d random writes", act_cnt - a0, N_RAND));
		if (violations != 0)
			report_error($sformatf("%0d protocol violations after row misses", violations));
	endtask

	task automatic programmed_timing();
		int p0;
		logic [`MC_ADDR_W-1:0] a;
		write_cfg(2'd0, 16'd9);
		write_cfg(2'd1, 16'd6);
		p0 = pre_cnt;
		addr_q.delete();
		for (int i = 0; i < N_PROG; i++) begin
			a = {`MC_BANK_W'(5), `MC_ROW_W'(i % 2 + 1), `MC_COL_W'(i)}; // rows alternate
			addr_q.push_back(a);
			send_req(1'b1, a, `MC_DATA_W'(next_rand()));
		end
		for (int i = 0; i < N_PROG; i++)
			send_req(1'b0, addr_q[i], '0);
		wait_idle();
		if (pre_cnt - p0 < 2 * N_PROG - 1)
			report_error($sformatf("only %0d PRE for row conflicts", pre_cnt - p0));
		write_cfg(2'd0, 16'(`MC_TRCD_RST));
		write_cfg(2'd1, 16'(`MC_TRP_RST));
	endtask

	task automatic refresh_under_load();
		int r0;
		int idx;
		logic [31:0] coin;
		write_cfg(2'd2, 16'd40);
		r0 = ref_cnt;
		addr_q.delete();
		for (int i = 0; i < N_MIX; i++) begin
			coin = next_rand();
			if (i == 0 || coin[0]) begin
				addr_q.push_back(`MC_ADDR_W'(next_rand()));
				send_req(1'b1, addr_q[addr_q.size() - 1], `MC_DATA_W'(next_rand()));
			end else begin
				idx = int'(next_rand() % 32'(addr_q.size()));
				send_req(1'b0, addr_q[idx], '0);
			end
		end
		wait_idle();
		if (ref_cnt == r0)
			report_error("no REF seen with trefi 40");
		if (violations != 0)
			report_error($sformatf("%0d protocol violations around refresh", violations));
		write_cfg(2'd2, 16'(`MC_TREFI_RST));
	endtask

	task automatic back_pressure();
		write_cfg(2'd0, 16'd30);
		addr_q.delete();
		busy_seen  = 1'b0;
		busy_check = 1'b1;
		for (int i = 0; i < N_BP; i++) begin
			addr_q.push_back(`MC_ADDR_W'(next_rand()));
			send_req(1'b1, addr_q[i], `MC_DATA_W'(next_rand())); // back to back
		end
		busy_check = 1'b0;
		wait_idle();
		if (!busy_seen)
			report_error("out_busy never rose with the FIFO full");
		for (int i = 0; i < N_BP; i++)
			send_req(1'b0, addr_q[i], '0);
		wait_idle();
		write_cfg(2'd0, 16'(`MC_TRCD_RST));
	endtask

	initial begin
		errors      = 0;
		wr_accepted = 0;
		rd_accepted = 0;
		wdone_cnt   = 0;
		rdone_cnt   = 0;
		act_cnt     = 0;
		pre_cnt     = 0;
		ref_cnt     = 0;
		last_pre    = -1000;
		last_ref    = -1000;
		cur_trcd    = `MC_TRCD_RST;
		cur_trp     = `MC_TRP_RST;
		cur_trfc    = `MC_TRFC_RST;
		rng         = 32'h96a1;
		busy_check  = 1'b0;
		busy_seen   = 1'b0;
		rd_issued   = 1'b0;
		for (int b = 0; b < NBANK; b++) begin
			act_cyc[b] = -1000;
			pre_cyc[b] = -1000;
		end
		arst_n             = 1'b0;
		in_valid           = 1'b0;
		in_request_type    = 1'b0;
		in_request_address = '0;
		in_request_data    = '0;
		cfg_we             = 1'b0;
		cfg_addr           = 2'd0;
		cfg_wdata          = 16'd0;

		check_reset_state();
		write_read_sequential();
		random_row_misses();
		programmed_timing();
		refresh_under_load();
		back_pressure();

		if (violations != 0)
			report_error($sformatf("DRAM model counted %0d protocol violations", violations));
		$display("errors %0d, protocol violations %0d, refreshes %0d, writes %0d, reads %0d",
			errors, violations, ref_cnt, wr_accepted, rd_accepted);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/dram_model.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mc_params.svh"

module dram_model #(
	parameter int TRFC = `MC_TRFC_RST
) (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   mc_pkg::mc_cmd_t dram_cmd,
	input  wire  [`MC_DATA_W-1:0] dram_wdata,
	output logic [`MC_DATA_W-1:0] dram_rdata,
	output int                    violations
);
	import mc_pkg::*;

	localparam int NBANK = 1 << `MC_BANK_W;

	logic [`MC_DATA_W-1:0] mem [logic [`MC_ADDR_W-1:0]]; // sparse storage
	logic [NBANK-1:0]      open;
	logic [`MC_ROW_W-1:0]  open_row [NBANK];
	logic [`MC_BANK_W-1:0] bank;
	logic [`MC_ADDR_W-1:0] addr;
	int                    since_ref; // cycles since the last REF
	int                    bad;

	// unwritten cells read back a value made from the whole address
	function automatic logic [`MC_DATA_W-1:0] fill(input logic [`MC_ADDR_W-1:0] a);
		return `MC_DATA_W'(a ^ (a >> `MC_DATA_W));
	endfunction

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			open       <= '0;
			since_ref  <= 1000;
			violations <= 0;
			dram_rdata <= '0;
		end else begin
			bad = 0;
			if (since_ref < 1000)
				since_ref <= since_ref + 1;
			if (dram_cmd.op != NOP && since_ref < TRFC)
				bad++; // still refreshing
			case (dram_cmd.op)
				ACT: begin
					bank = dram_cmd.payload.act.bank;
					if (open[bank])
						bad++;
					open[bank]     <= 1'b1;
					open_row[bank] <= dram_cmd.payload.act.row;
				end
				PRE: open[dram_cmd.payload.act.bank] <= 1'b0;
				RD, WR: begin
					bank = dram_cmd.payload.col.bank;
					addr = {bank, open_row[bank], dram_cmd.payload.col.col};
					if (!open[bank])
						bad++;
					else if (dram_cmd.op == WR)
						mem[addr] = dram_wdata;
					else
						dram_rdata <= mem.exists(addr) ? mem[addr] : fill(addr);
				end
				REF: begin
					if (|open)
						bad++; // all banks must be closed
					since_ref <= 1;
				end
				default: ;
			endcase
			violations <= violations + bad;
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 10 // 20 ns period
) (
	output logic clk
);
	initial clk = 1'b0;

	always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// ==== hdl/memory_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mc_params.svh"

module memory_controller (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   in_valid,
	input  wire                   in_request_type,
	input  wire  [`MC_ADDR_W-1:0] in_request_address,
	input  wire  [`MC_DATA_W-1:0] in_request_data,
	output logic                  out_busy,
	output logic                  write_done,
	output logic                  read_done,
	output logic [`MC_DATA_W-1:0] data_out,
	input  wire                   cfg_we,
	input  wire  [1:0]            cfg_addr,
	input  wire  [15:0]           cfg_wdata,
	output mc_pkg::mc_cmd_t       dram_cmd,
	output logic [`MC_DATA_W-1:0] dram_wdata,
	input  wire  [`MC_DATA_W-1:0] dram_rdata
);
	import mc_pkg::*;

	mc_req_t    push_req;
	mc_req_t    head;
	mc_timing_t timing;
	logic       push, pop, not_empty, full;

	assign push_req = '{is_write: in_request_type, addr: in_request_address,
		data: in_request_data};
	assign push     = in_valid && !full; // client holds while busy
	assign out_busy = full;

	mc_request_fifo i_mc_request_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (push),
		.push_req  (push_req),
		.pop       (pop),
		.head      (head),
		.not_empty (not_empty),
		.full      (full)
	);

	mc_timing_regs i_mc_timing_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.timing    (timing)
	);

	mc_cmd_sequencer i_mc_cmd_sequencer (
		.clk        (clk),
		.arst_n     (arst_n),
		.timing     (timing),
		.head       (head),
		.not_empty  (not_empty),
		.pop        (pop),
		.dram_cmd   (dram_cmd),
		.dram_wdata (dram_wdata),
		.dram_rdata (dram_rdata),
		.write_done (write_done),
		.read_done  (read_done),
		.data_out   (data_out)
	);

endmodule

`default_nettype wire

// ==== hdl/mc_cmd_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mc_params.svh"

module mc_cmd_sequencer (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    mc_pkg::mc_timing_t timing,
	input  wire                    mc_pkg::mc_req_t head,
	input  wire                    not_empty,
	output logic                   pop,
	output mc_pkg::mc_cmd_t        dram_cmd,
	output logic [`MC_DATA_W-1:0]  dram_wdata,
	input  wire  [`MC_DATA_W-1:0]  dram_rdata,
	output logic                   write_done,
	output logic                   read_done,
	output logic [`MC_DATA_W-1:0]  data_out
);
	import mc_pkg::*;

	localparam int BANK_W = `MC_BANK_W;
	localparam int NBANK  = 1 << BANK_W;

	typedef enum logic [2:0] {IDLE, PRECHARGE, ACTIVATE, ACCESS, REFRESH} state_e;

	state_e                state, state_nxt;
	state_e                goal;      // what this cycle works towards
	mc_cmd_t               cmd;
	logic [7:0]            wait_cnt;  // cycles left until the next command may go
	logic [7:0]            wait_load;
	logic                  wait_set;
	logic                  wait_done;
	logic [15:0]           ref_cnt;
	logic                  ref_pending;
	logic [NBANK-1:0]      row_valid; // open-row table
	logic [`MC_ROW_W-1:0]  row_addr [NBANK];
	logic [BANK_W-1:0]     head_bank, first_open, pre_bank;
	logic [`MC_ROW_W-1:0]  head_row;
	logic [`MC_COL_W-1:0]  head_col;
	logic                  any_open, row_hit, need_pre;
	logic                  rd_pending;
	logic [`MC_DATA_W-1:0] rd_hold;

	assign {head_bank, head_row, head_col} = head.addr;
	assign any_open  = |row_valid;
	assign row_hit   = row_valid[head_bank] && (row_addr[head_bank] == head_row);
	assign wait_done = (wait_cnt == 8'd0);

	// lowest open bank, closed first during refresh
	always_comb begin
		first_open = '0;
		for (int i = NBANK - 1; i >= 0; i--) begin
			if (row_valid[i])
				first_open = BANK_W'(i);
		end
	end

	always_comb begin
		goal = state;
		if (state == IDLE) begin
			if (ref_pending)
				goal = any_open ? PRECHARGE : REFRESH;
			else if (not_empty) begin
				if (row_hit)
					goal = ACCESS;
				else if (row_valid[head_bank])
					goal = PRECHARGE; // row conflict
				else
					goal = ACTIVATE;
			end
		end
		need_pre = ref_pending ? any_open : row_valid[head_bank];
		pre_bank = ref_pending ? first_open : head_bank;
		// trp has run out, go on in the same cycle
		if (goal == PRECHARGE && !need_pre && wait_done)
			goal = ref_pending ? REFRESH : ACTIVATE;

		state_nxt = state;
		cmd       = '0;
		pop       = 1'b0;
		wait_set  = 1'b0;
		wait_load = 8'd0;
		case (goal)
			PRECHARGE: begin
				if (need_pre) begin // back to back while closing for refresh
					cmd.op               = PRE;
					cmd.payload.act.bank = pre_bank;
					wait_set             = 1'b1;
					wait_load            = timing.trp - 8'd1;
					state_nxt            = PRECHARGE;
				end
			end
			ACTIVATE: begin
				cmd.op               = ACT;
				cmd.payload.act.bank = head_bank;
				cmd.payload.act.row  = head_row;
				wait_set             = 1'b1;
				wait_load            = timing.trcd - 8'd1;
				state_nxt            = ACCESS;
			end
			ACCESS: begin
				if (wait_done) begin
					cmd.op               = head.is_write ? WR : RD;
					cmd.payload.col.bank = head_bank;
					cmd.payload.col.col  = head_col;
					pop                  = 1'b1;
					state_nxt            = IDLE;
				end
			end
			REFRESH: begin
				if (ref_pending) begin
					cmd.op    = REF;
					wait_set  = 1'b1;
					wait_load = timing.trfc - 8'd1;
					state_nxt = REFRESH;
				end else if (wait_done) begin
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= IDLE;
			wait_cnt    <= 8'd0;
			ref_cnt     <= 16'd0;
			ref_pending <= 1'b0;
			row_valid   <= '0;
			rd_pending  <= 1'b0;
		end else begin
			state      <= state_nxt;
			rd_pending <= (cmd.op == RD);
			if (wait_set)
				wait_cnt <= wait_load;
			else if (!wait_done)
				wait_cnt <= wait_cnt - 8'd1;
			if (cmd.op == ACT)
				row_valid[cmd.payload.act.bank] <= 1'b1;
			else if (cmd.op == PRE)
				row_valid[cmd.payload.act.bank] <= 1'b0;
			if (cmd.op == REF)
				ref_pending <= 1'b0;
			else if (state != REFRESH && ref_cnt >= timing.trefi)
				ref_pending <= 1'b1;
			if (state == REFRESH)
				ref_cnt <= 16'd0; // interval restarts once trfc is over
			else if (!ref_pending)
				ref_cnt <= ref_cnt + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.op == ACT)
			row_addr[cmd.payload.act.bank] <= cmd.payload.act.row;
		if (rd_pending)
			rd_hold <= dram_rdata;
	end

	assign dram_cmd   = cmd;
	assign dram_wdata = head.data;
	assign write_done = (cmd.op == WR);
	assign read_done  = rd_pending;
	assign data_out   = rd_pending ? dram_rdata : rd_hold; // live on the return cycle

	a_access_open_bank: assert property (@(posedge clk) disable iff (!arst_n)
		(dram_cmd.op inside {RD, WR}) |-> row_valid[dram_cmd.payload.col.bank]);
	a_ref_all_closed: assert property (@(posedge clk) disable iff (!arst_n)
		(dram_cmd.op == REF) |-> !any_open);

endmodule

`default_nettype wire

// ==== hdl/mc_timing_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mc_params.svh"

module mc_timing_regs (
	input  wire                clk,
	input  wire                arst_n,
	input  wire                cfg_we,
	input  wire  [1:0]         cfg_addr,
	input  wire  [15:0]        cfg_wdata,
	output mc_pkg::mc_timing_t timing
);
	// register map
	localparam logic [1:0] ADDR_TRCD  = 2'd0;
	localparam logic [1:0] ADDR_TRP   = 2'd1;
	localparam logic [1:0] ADDR_TREFI = 2'd2;
	localparam logic [1:0] ADDR_TRFC  = 2'd3;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			timing.trcd  <= 8'(`MC_TRCD_RST);
			timing.trp   <= 8'(`MC_TRP_RST);
			timing.trefi <= 16'(`MC_TREFI_RST);
			timing.trfc  <= 8'(`MC_TRFC_RST);
		end else if (cfg_we) begin
			case (cfg_addr)
				ADDR_TRCD:  timing.trcd  <= cfg_wdata[7:0]; // upper byte dropped
				ADDR_TRP:   timing.trp   <= cfg_wdata[7:0];
				ADDR_TREFI: timing.trefi <= cfg_wdata;
				ADDR_TRFC:  timing.trfc  <= cfg_wdata[7:0];
				default:    timing.trfc  <= timing.trfc;
			endcase
		end
	end

	// sequencer loads value-1 into its wait counter, zero would wrap
	a_timing_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
		(timing.trcd != 8'd0) && (timing.trp != 8'd0) && (timing.trfc != 8'd0));

endmodule

`default_nettype wire

// ==== hdl/mc_request_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mc_params.svh"

module mc_request_fifo (
	input  wire             clk,
	input  wire             arst_n,
	input  wire             push,
	input  wire             mc_pkg::mc_req_t push_req,
	input  wire             pop,
	output mc_pkg::mc_req_t head,
	output logic            not_empty,
	output logic            full
);
	import mc_pkg::*;

	localparam int DEPTH = `MC_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	mc_req_t          mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count; // one extra bit to tell full from empty

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_req;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	assign head      = mem[rd_ptr];
	assign not_empty = (count != '0);
	assign full      = (count == (PTR_W+1)'(DEPTH));

	// sequencer only pops a request it has seen
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> not_empty);
	// top level holds writes off while busy
	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);

endmodule

`default_nettype wire

// ==== hdl/mc_pkg.sv ====
`default_nettype none

`include "mc_params.svh"

package mc_pkg;

	// one client request as held in the queue
	typedef struct packed {
		logic                  is_write; // 1 = write, 0 = read
		logic [`MC_ADDR_W-1:0] addr;
		logic [`MC_DATA_W-1:0] data;
	} mc_req_t;

	typedef enum logic [2:0] {
		NOP = 3'd0,
		ACT = 3'd1,
		RD  = 3'd2,
		WR  = 3'd3,
		PRE = 3'd4,
		REF = 3'd5
	} mc_op_e;

	// ACT and PRE carry a row
	typedef struct packed {
		logic [`MC_BANK_W-1:0] bank;
		logic [`MC_ROW_W-1:0]  row;
		logic [`MC_COL_W-1:0]  pad;
	} mc_act_fields_t;

	// RD and WR carry a column
	typedef struct packed {
		logic [`MC_BANK_W-1:0] bank;
		logic [`MC_COL_W-1:0]  col;
		logic [`MC_ROW_W-1:0]  pad;
	} mc_col_fields_t;

	typedef union packed {
		mc_act_fields_t act;
		mc_col_fields_t col;
	} mc_cmd_payload_u;

	typedef struct packed {
		mc_op_e          op;
		mc_cmd_payload_u payload;
	} mc_cmd_t;

	typedef struct packed {
		logic [7:0]  trcd;
		logic [7:0]  trp;
		logic [7:0]  trfc;
		logic [15:0] trefi;
	} mc_timing_t;

endpackage

`default_nettype wire

// ==== include/mc_params.svh ====
`ifndef MC_PARAMS_SVH
`define MC_PARAMS_SVH

// data path
`define MC_DATA_W 16

// address layout: bank | row | column
`define MC_BANK_W 4
`define MC_ROW_W 16
`define MC_COL_W 10
`define MC_ADDR_W (`MC_BANK_W + `MC_ROW_W + `MC_COL_W)

// request queue
`define MC_FIFO_DEPTH 4

// timing register reset values, in clk cycles
`define MC_TRCD_RST 4
`define MC_TRP_RST 3
`define MC_TREFI_RST 400
`define MC_TRFC_RST 8

`endif
